// File: src/raster_pkg.sv
package raster_pkg;

    localparam int SCREEN_W     = 320;
    localparam int SCREEN_H     = 240;
    localparam int SUBPIX_BITS  = 3;
    localparam int RECIP_BITS   = 16;
    localparam int RECIP_SHIFT  = 44;  // Reciprocal is 2^44 / |denom|
    localparam int WEIGHT_FRAC  = 16;
    localparam int WEIGHT_SHIFT = RECIP_SHIFT - WEIGHT_FRAC;

    typedef logic signed [31:0] q16_16_t;
    typedef logic [11:0]        color12_t;  // RGB444, red on top
    typedef logic signed [18:0] coord_t;    // Q16.3
    typedef logic signed [37:0] dot_t;      // Q32.6
    typedef logic signed [75:0] wide_t;     // Q64.12

    typedef struct packed {
        coord_t   x;
        coord_t   y;
        color12_t color;
        q16_16_t  depth;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_in_t;

    typedef struct packed {
        coord_t                v0x, v0y;
        coord_t                e0x, e0y;  // v1 - v0
        coord_t                e1x, e1y;  // v2 - v0
        dot_t                  d00, d01, d11;
        logic                  denom_neg;
        logic [RECIP_BITS-1:0] denom_inv;
        color12_t              v0_color, v1_color, v2_color;
        q16_16_t               v0_depth, v1_depth, v2_depth;
        logic [15:0]           xmin, xmax;  // Whole pixels, clipped
        logic [15:0]           ymin, ymax;
    } tri_setup_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        tri_setup_t  triangle;
    } pixel_state_t;

    typedef struct packed {
        logic         valid;
        pixel_state_t pixel;
        wide_t        v_num, w_num;
        wide_t        denom;
    } pixel_eval_stage1_t;

    typedef struct packed {
        logic         valid;
        pixel_state_t pixel;
        wide_t        v_num, w_num, u_num;
    } pixel_eval_stage2_t;

    typedef struct packed {
        logic         valid;
        pixel_state_t pixel;
        wide_t        v_num, w_num;
        logic         is_inside;
    } pixel_eval_stage3_t;

    typedef struct packed {
        logic         valid;
        pixel_state_t pixel;
        color12_t     color;
        q16_16_t      depth;
    } pixel_output_t;

    typedef enum logic {IDLE, SCAN} walk_state_t;

    typedef enum logic [1:0] {R_IDLE, R_RUN, R_DONE} recip_state_t;

endpackage

// File: src/recip_unit.sv
`timescale 1ns/1ps

module recip_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [75:0] magnitude,
    output logic [15:0] recip,
    output logic        done
);
    import raster_pkg::*;

    recip_state_t          state;
    logic [3:0]            bit_cnt;
    logic [75:0]           divisor;
    logic [76:0]           rem;
    logic [76:0]           rem_shift;
    logic [76:0]           dividend_top;
    logic [RECIP_BITS-1:0] quot;
    logic                  sat;

    // Upper dividend bits, the low quotient bits shift in as zeros
    assign dividend_top = 77'd1 << (RECIP_SHIFT - RECIP_BITS);
    assign rem_shift    = {rem[75:0], 1'b0};
    assign done         = (state == R_DONE);
    assign recip        = sat ? '1 : quot;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= R_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    bit_cnt <= '0;
                    if (start) begin
                        state <= R_RUN;  // Load cycle
                    end
                end
                R_RUN: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(RECIP_BITS - 1)) begin
                        state <= R_DONE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && start) begin
            divisor <= magnitude;
            rem     <= dividend_top;
            quot    <= '0;
            sat     <= {1'b0, magnitude} <= dividend_top;  // Overflow or zero
        end else if (state == R_RUN) begin
            if (rem_shift >= {1'b0, divisor}) begin
                rem  <= rem_shift - {1'b0, divisor};
                quot <= {quot[RECIP_BITS-2:0], 1'b1};
            end else begin
                rem  <= rem_shift;
                quot <= {quot[RECIP_BITS-2:0], 1'b0};
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> state == R_IDLE);

endmodule

// File: src/tri_setup.sv
`timescale 1ns/1ps

module tri_setup (
    input  logic                   clk,
    input  logic                   rst,
    input  raster_pkg::tri_in_t    tri_in,
    input  logic                   tri_valid,
    output logic                   tri_ready,
    output raster_pkg::tri_setup_t setup,
    output logic                   setup_valid,
    input  logic                   setup_ready
);
    import raster_pkg::*;

    tri_in_t               tri_q;
    coord_t                e0x, e0y, e1x, e1y;
    wide_t                 denom;
    logic [75:0]           magnitude;
    logic [RECIP_BITS-1:0] recip;
    logic                  recip_done;
    logic                  accept;
    logic                  load_q;   // Edges and dots register this cycle
    logic                  start_q;
    logic                  calc_q;   // Held until the reciprocal lands

    // Floor of the smallest coordinate in whole pixels
    function automatic int lo_px(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        m = (m < c) ? m : c;
        return m >>> SUBPIX_BITS;
    endfunction

    function automatic int hi_px(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        m = (m > c) ? m : c;
        return (m + (1 << SUBPIX_BITS) - 1) >>> SUBPIX_BITS;  // Ceiling
    endfunction

    function automatic logic [15:0] clamp_px(input int v, input int hi);
        return (v < 0) ? 16'd0 : (v > hi) ? 16'(hi) : 16'(v);
    endfunction

    assign accept    = tri_valid && tri_ready;
    assign e0x       = tri_q.v1.x - tri_q.v0.x;
    assign e0y       = tri_q.v1.y - tri_q.v0.y;
    assign e1x       = tri_q.v2.x - tri_q.v0.x;
    assign e1y       = tri_q.v2.y - tri_q.v0.y;
    assign denom     = setup.d00 * setup.d11 - setup.d01 * setup.d01;
    assign magnitude = denom[75] ? -denom : denom;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tri_ready   <= 1'b0;
            load_q      <= 1'b0;
            start_q     <= 1'b0;
            calc_q      <= 1'b0;
            setup_valid <= 1'b0;
        end else begin
            load_q  <= accept;
            start_q <= load_q;
            if (accept) begin
                calc_q <= 1'b1;
            end else if (recip_done) begin
                calc_q <= 1'b0;
            end
            if (recip_done) begin
                setup_valid <= 1'b1;
            end else if (setup_ready) begin
                setup_valid <= 1'b0;
            end
            tri_ready <= !accept && !calc_q && !(setup_valid && !setup_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tri_q <= tri_in;
        end
        if (load_q) begin
            setup.v0x      <= tri_q.v0.x;
            setup.v0y      <= tri_q.v0.y;
            setup.e0x      <= e0x;
            setup.e0y      <= e0y;
            setup.e1x      <= e1x;
            setup.e1y      <= e1y;
            setup.d00      <= e0x * e0x + e0y * e0y;
            setup.d01      <= e0x * e1x + e0y * e1y;
            setup.d11      <= e1x * e1x + e1y * e1y;
            setup.v0_color <= tri_q.v0.color;
            setup.v1_color <= tri_q.v1.color;
            setup.v2_color <= tri_q.v2.color;
            setup.v0_depth <= tri_q.v0.depth;
            setup.v1_depth <= tri_q.v1.depth;
            setup.v2_depth <= tri_q.v2.depth;
            setup.xmin <= clamp_px(lo_px(tri_q.v0.x, tri_q.v1.x, tri_q.v2.x), SCREEN_W - 1);
            setup.xmax <= clamp_px(hi_px(tri_q.v0.x, tri_q.v1.x, tri_q.v2.x), SCREEN_W - 1);
            setup.ymin <= clamp_px(lo_px(tri_q.v0.y, tri_q.v1.y, tri_q.v2.y), SCREEN_H - 1);
            setup.ymax <= clamp_px(hi_px(tri_q.v0.y, tri_q.v1.y, tri_q.v2.y), SCREEN_H - 1);
        end
        if (start_q) begin
            setup.denom_neg <= denom[75];
        end
        if (recip_done) begin
            setup.denom_inv <= recip;
        end
    end

    recip_unit recip_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start_q),
        .magnitude (magnitude),
        .recip     (recip),
        .done      (recip_done)
    );

    assert property (@(posedge clk) disable iff (rst)
        setup_valid && !setup_ready |=> setup_valid && $stable(setup));

endmodule

// File: src/bbox_walker.sv
`timescale 1ns/1ps

module bbox_walker (
    input  logic                     clk,
    input  logic                     rst,
    input  raster_pkg::tri_setup_t   setup,
    input  logic                     setup_valid,
    output logic                     setup_ready,
    output raster_pkg::pixel_state_t pix,
    output logic                     pix_valid,
    input  logic                     pix_ready
);
    import raster_pkg::*;

    walk_state_t state;
    tri_setup_t  tri_q;
    logic [15:0] x;
    logic [15:0] y;
    logic        last_x;
    logic        last_y;

    assign setup_ready  = (state == IDLE);
    assign pix_valid    = (state == SCAN);
    assign last_x       = (x >= tri_q.xmax);
    assign last_y       = (y >= tri_q.ymax);
    assign pix.x        = x;
    assign pix.y        = y;
    assign pix.triangle = tri_q;  // Same setup rides with every pixel

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (setup_valid) begin
                        state <= SCAN;
                        x     <= setup.xmin;
                        y     <= setup.ymin;
                    end
                end
                SCAN: begin
                    if (pix_ready) begin
                        if (!last_x) begin
                            x <= x + 16'd1;
                        end else begin
                            x <= tri_q.xmin;  // Next row
                            if (last_y) begin
                                state <= IDLE;
                            end else begin
                                y <= y + 16'd1;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (setup_valid && setup_ready) begin
            tri_q <= setup;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> x >= tri_q.xmin && x <= tri_q.xmax && y >= tri_q.ymin && y <= tri_q.ymax);

endmodule

// File: src/pixel_eval.sv
`timescale 1ns/1ps

module pixel_eval (
    input  logic                     clk,
    input  logic                     rst,
    input  raster_pkg::pixel_state_t in_pixel,
    input  logic                     in_valid,
    output logic                     in_ready,
    output logic [15:0]              out_x,
    output logic [15:0]              out_y,
    output raster_pkg::color12_t     out_color,
    output raster_pkg::q16_16_t      out_depth,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     busy
);
    import raster_pkg::*;

    pixel_eval_stage1_t s1, s1_next;
    pixel_eval_stage2_t s2, s2_next;
    pixel_eval_stage3_t s3, s3_next;
    pixel_output_t      s4, s4_next;
    logic               s1_load, s2_load, s3_load, s4_load, out_load;
    tri_setup_t         t1, t3;
    coord_t             e2x, e2y;   // Pixel relative to v0, Q16.3
    dot_t               d20, d21;
    q16_16_t            wu, wv, ww;

    // |num| * 2^44/|denom| back down to Q16.16, rounded
    function automatic q16_16_t to_weight(input wide_t num, input logic neg,
                                          input logic [RECIP_BITS-1:0] inv);
        wide_t              mag;
        logic signed [92:0] prod;
        mag  = neg ? -num : num;
        prod = mag * $signed({1'b0, inv});
        return q16_16_t'((prod + (93'sd1 <<< (WEIGHT_SHIFT - 1))) >>> WEIGHT_SHIFT);
    endfunction

    function automatic q16_16_t blend(input q16_16_t u, v, w, input q16_16_t a, b, c);
        logic signed [65:0] acc;
        acc = u * a + v * b + w * c + (66'sd1 <<< (WEIGHT_FRAC - 1));
        return q16_16_t'(acc >>> WEIGHT_FRAC);
    endfunction

    function automatic logic [3:0] blend_nibble(input q16_16_t u, v, w,
                                                input logic [3:0] a, b, c);
        q16_16_t mix;
        mix = blend(u, v, w, q16_16_t'(a), q16_16_t'(b), q16_16_t'(c));
        return mix[3:0];
    endfunction

    // A register loads when empty or when its successor loads
    assign out_load = !out_valid || out_ready;
    assign s4_load  = !s4.valid || out_load;
    assign s3_load  = !s3.valid || s4_load;
    assign s2_load  = !s2.valid || s3_load;
    assign s1_load  = !s1.valid || s2_load;
    assign in_ready = s1_load;
    assign busy     = s1.valid || s2.valid || s3.valid || s4.valid || out_valid;

    assign t1  = in_pixel.triangle;
    assign e2x = coord_t'({in_pixel.x, {SUBPIX_BITS{1'b0}}}) - t1.v0x;
    assign e2y = coord_t'({in_pixel.y, {SUBPIX_BITS{1'b0}}}) - t1.v0y;
    assign d20 = e2x * t1.e0x + e2y * t1.e0y;
    assign d21 = e2x * t1.e1x + e2y * t1.e1y;

    always_comb begin
        s1_next.valid = in_valid;
        s1_next.pixel = in_pixel;
        s1_next.v_num = t1.d11 * d20 - t1.d01 * d21;
        s1_next.w_num = t1.d00 * d21 - t1.d01 * d20;
        s1_next.denom = t1.d00 * t1.d11 - t1.d01 * t1.d01;
    end

    always_comb begin
        s2_next.valid = s1.valid;
        s2_next.pixel = s1.pixel;
        s2_next.v_num = s1.v_num;
        s2_next.w_num = s1.w_num;
        s2_next.u_num = s1.denom - s1.v_num - s1.w_num;
    end

    // Inside when all numerators follow the denominator sign, zero included
    always_comb begin
        s3_next.valid = s2.valid;
        s3_next.pixel = s2.pixel;
        s3_next.v_num = s2.v_num;
        s3_next.w_num = s2.w_num;
        if (s2.pixel.triangle.denom_neg) begin
            s3_next.is_inside = s2.u_num <= 0 && s2.v_num <= 0 && s2.w_num <= 0;
        end else begin
            s3_next.is_inside = s2.u_num >= 0 && s2.v_num >= 0 && s2.w_num >= 0;
        end
    end

    assign t3 = s3.pixel.triangle;
    assign wv = to_weight(s3.v_num, t3.denom_neg, t3.denom_inv);
    assign ww = to_weight(s3.w_num, t3.denom_neg, t3.denom_inv);
    assign wu = (q16_16_t'(1) <<< WEIGHT_FRAC) - wv - ww;

    always_comb begin
        s4_next.valid = s3.valid && s3.is_inside;  // Uncovered pixels end here
        s4_next.pixel = s3.pixel;
        for (int i = 0; i < 3; i++) begin
            s4_next.color[4*i +: 4] = blend_nibble(wu, wv, ww, t3.v0_color[4*i +: 4],
                                                   t3.v1_color[4*i +: 4],
                                                   t3.v2_color[4*i +: 4]);
        end
        s4_next.depth = blend(wu, wv, ww, t3.v0_depth, t3.v1_depth, t3.v2_depth);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1        <= '0;
            s2        <= '0;
            s3        <= '0;
            s4        <= '0;
            out_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                s1 <= s1_next;
            end
            if (s2_load) begin
                s2 <= s2_next;
            end
            if (s3_load) begin
                s3 <= s3_next;
            end
            if (s4_load) begin
                s4 <= s4_next;
            end
            if (out_load) begin
                out_valid <= s4.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_x     <= s4.pixel.x;
            out_y     <= s4.pixel.y;
            out_color <= s4.color;
            out_depth <= s4.depth;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_x, out_y, out_color, out_depth}));

endmodule

// File: src/raster_top.sv
`timescale 1ns/1ps

module raster_top (
    input  logic                 clk,
    input  logic                 rst,
    input  raster_pkg::tri_in_t  tri_in,
    input  logic                 tri_valid,
    output logic                 tri_ready,
    output logic [15:0]          out_x,
    output logic [15:0]          out_y,
    output raster_pkg::color12_t out_color,
    output raster_pkg::q16_16_t  out_depth,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 busy
);
    import raster_pkg::*;

    tri_setup_t   setup;
    logic         setup_valid;
    logic         setup_ready;
    pixel_state_t pix;
    logic         pix_valid;   // Also marks the walker out of IDLE
    logic         pix_ready;
    logic         eval_busy;

    assign busy = eval_busy || setup_valid || pix_valid;

    tri_setup tri_setup_inst (
        .clk         (clk),
        .rst         (rst),
        .tri_in      (tri_in),
        .tri_valid   (tri_valid),
        .tri_ready   (tri_ready),
        .setup       (setup),
        .setup_valid (setup_valid),
        .setup_ready (setup_ready)
    );

    bbox_walker bbox_walker_inst (
        .clk         (clk),
        .rst         (rst),
        .setup       (setup),
        .setup_valid (setup_valid),
        .setup_ready (setup_ready),
        .pix         (pix),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready)
    );

    pixel_eval pixel_eval_inst (
        .clk       (clk),
        .rst       (rst),
        .in_pixel  (pix),
        .in_valid  (pix_valid),
        .in_ready  (pix_ready),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_color (out_color),
        .out_depth (out_depth),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (eval_busy)
    );

endmodule

// File: testbench/raster_ref.svh
`ifndef RASTER_REF_SVH
`define RASTER_REF_SVH

typedef logic signed [127:0] big_t;

typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    color12_t    color;
    q16_16_t     depth;
} exp_pixel_t;

// Floor of the smallest vertex coordinate clipped to 0..lim
function automatic int box_lo(input int a, input int b, input int c, input int lim);
    int m;
    m = (a < b) ? a : b;
    m = (c < m) ? c : m;
    m = m >>> SUBPIX_BITS;
    return (m < 0) ? 0 : (m > lim) ? lim : m;
endfunction

function automatic int box_hi(input int a, input int b, input int c, input int lim);
    int m;
    m = (a > b) ? a : b;
    m = (c > m) ? c : m;
    m = -((-m) >>> SUBPIX_BITS);  // Ceiling
    return (m < 0) ? 0 : (m > lim) ? lim : m;
endfunction

function automatic int box_area(input tri_in_t t);
    int w;
    int h;
    w = box_hi(t.v0.x, t.v1.x, t.v2.x, SCREEN_W - 1) - box_lo(t.v0.x, t.v1.x, t.v2.x, SCREEN_W - 1);
    h = box_hi(t.v0.y, t.v1.y, t.v2.y, SCREEN_H - 1) - box_lo(t.v0.y, t.v1.y, t.v2.y, SCREEN_H - 1);
    return (w + 1) * (h + 1);
endfunction

// 2^44 / magnitude or all ones when it does not fit in 16 bits
function automatic logic [15:0] recip_floor(input big_t mag);
    big_t q;
    q = (mag == 0) ? big_t'(65536) : (big_t'(1) <<< RECIP_SHIFT) / mag;
    return (q > 65535) ? 16'hffff : q[15:0];
endfunction

function automatic q16_16_t weight_q16(input big_t num, input big_t den, input logic [15:0] inv);
    big_t mag;
    mag = (den < 0) ? -num : num;
    return q16_16_t'((mag * $signed({1'b0, inv}) + (big_t'(1) <<< 27)) >>> 28);
endfunction

function automatic q16_16_t mix_rounded(input q16_16_t u, input q16_16_t v, input q16_16_t w,
                                        input big_t a, input big_t b, input big_t c);
    big_t acc;
    acc = u * a + v * b + w * c + (big_t'(1) <<< 15);  // Round to nearest
    return q16_16_t'(acc >>> 16);
endfunction

function automatic bit covered(input big_t u, input big_t v, input big_t w, input big_t den);
    if (den < 0) begin
        return u <= 0 && v <= 0 && w <= 0;
    end
    return u >= 0 && v >= 0 && w >= 0;
endfunction

// Expected covered pixels of one triangle in raster order
task automatic model_triangle(input tri_in_t t, ref exp_pixel_t q[$]);
    int          x0, y0, px, py;
    big_t        e0x, e0y, e1x, e1y, d00, d01, d11, d20, d21, den, vn, wn, un;
    logic [15:0] inv;
    q16_16_t     wu, wv, ww;
    exp_pixel_t  p;
    x0  = t.v0.x;
    y0  = t.v0.y;
    e0x = t.v1.x - t.v0.x;
    e0y = t.v1.y - t.v0.y;
    e1x = t.v2.x - t.v0.x;
    e1y = t.v2.y - t.v0.y;
    d00 = e0x * e0x + e0y * e0y;
    d01 = e0x * e1x + e0y * e1y;
    d11 = e1x * e1x + e1y * e1y;
    den = d00 * d11 - d01 * d01;
    inv = recip_floor((den < 0) ? -den : den);
    for (int y = box_lo(t.v0.y, t.v1.y, t.v2.y, SCREEN_H - 1);
         y <= box_hi(t.v0.y, t.v1.y, t.v2.y, SCREEN_H - 1); y++) begin
        for (int x = box_lo(t.v0.x, t.v1.x, t.v2.x, SCREEN_W - 1);
             x <= box_hi(t.v0.x, t.v1.x, t.v2.x, SCREEN_W - 1); x++) begin
            px  = (x << SUBPIX_BITS) - x0;  // Pixel corner
            py  = (y << SUBPIX_BITS) - y0;
            d20 = px * e0x + py * e0y;
            d21 = px * e1x + py * e1y;
            vn  = d11 * d20 - d01 * d21;
            wn  = d00 * d21 - d01 * d20;
            un  = den - vn - wn;
            if (covered(un, vn, wn, den)) begin
                wv  = weight_q16(vn, den, inv);
                ww  = weight_q16(wn, den, inv);
                wu  = 32'sh0001_0000 - wv - ww;
                p.x = 16'(x);
                p.y = 16'(y);
                for (int i = 0; i < 12; i += 4) begin
                    p.color[i +: 4] = 4'(mix_rounded(wu, wv, ww, t.v0.color[i +: 4],
                                                     t.v1.color[i +: 4], t.v2.color[i +: 4]));
                end
                p.depth = mix_rounded(wu, wv, ww, t.v0.depth, t.v1.depth, t.v2.depth);
                q.push_back(p);
            end
        end
    end
endtask

`endif

// File: testbench/raster_tb.sv
`timescale 1ns/1ps

module raster_tb;
    import raster_pkg::*;

    `include "raster_ref.svh"

    logic        clk;
    logic        rst;
    tri_in_t     tri_in;
    logic        tri_valid;
    logic        tri_ready;
    logic [15:0] out_x;
    logic [15:0] out_y;
    color12_t    out_color;
    q16_16_t     out_depth;
    logic        out_valid;
    logic        out_ready;
    logic        busy;

    exp_pixel_t  exp_q[$];
    exp_pixel_t  saved_q[$];  // Outputs of the first winding
    logic        saving;
    logic        matching;
    logic        random_ready;
    logic        ready_next;
    int          rnd;
    int          seed = 81683;
    int          cycle_count = 0;
    int          cycle_limit = 200;

    raster_top raster_top_inst (
        .clk       (clk),
        .rst       (rst),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .tri_ready (tri_ready),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_color (out_color),
        .out_depth (out_depth),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [127:0] expv,
                                 input logic [127:0] actv);
        report_fail($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, expv, actv));
    endtask

    function automatic vertex_t vtx(input int x, input int y, input color12_t c,
                                    input q16_16_t z);
        vertex_t v;
        v.x     = coord_t'(x);
        v.y     = coord_t'(y);
        v.color = c;
        v.depth = z;
        return v;
    endfunction

    // Called and returns at edge plus 1 ns
    task automatic send_tri(input tri_in_t t);
        tri_in    = t;
        tri_valid = 1'b1;
        @(negedge clk);
        while (!tri_ready) begin
            @(negedge clk);
        end
        model_triangle(t, exp_q);
        @(posedge clk);
        #1;
        tri_valid = 1'b0;
    endtask

    task automatic wait_idle();
        repeat (25) @(negedge clk);  // Past the setup latency
        while (busy) begin
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else report_fail("busy fell with pixels still expected");
        @(posedge clk);
        #1;
    endtask

    task automatic check_output();
        exp_pixel_t e;
        exp_pixel_t got;
        got.x     = out_x;
        got.y     = out_y;
        got.color = out_color;
        got.depth = out_depth;
        assert (exp_q.size() > 0) else report_fail("extra output pixel with none expected");
        e = exp_q.pop_front();
        assert (out_x < SCREEN_W && out_y < SCREEN_H) else report_fail("pixel outside the screen");
        assert (out_x == e.x) else show_mismatch("out_x", e.x, out_x);
        assert (out_y == e.y) else show_mismatch("out_y", e.y, out_y);
        assert (out_color == e.color) else show_mismatch("out_color", e.color, out_color);
        assert (out_depth == e.depth) else show_mismatch("out_depth", e.depth, out_depth);
        if (saving) begin
            saved_q.push_back(got);
        end
        if (matching) begin
            assert (saved_q.size() > 0) else report_fail("reverse winding gave an extra pixel");
            e = saved_q.pop_front();
            assert (got == e) else show_mismatch("reverse winding pixel", e, got);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            assert (!out_valid && !busy) else report_fail("out_valid or busy high during reset");
        end else if (out_valid && out_ready) begin
            check_output();
        end
    end

    always @(posedge clk) begin
        rnd        = $random(seed);
        ready_next = !random_ready || rnd[0];
        #1;
        out_ready  = ready_next;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_fail($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_x, out_y, out_color, out_depth}))
        else report_fail("output changed while stalled");

    initial begin
        tri_in_t tris[6];
        rst          = 1'b1;
        tri_in       = '0;
        tri_valid    = 1'b0;
        out_ready    = 1'b1;
        saving       = 1'b0;
        matching     = 1'b0;
        random_ready = 1'b0;
        // Colour gradient with differing depths and its v1/v2 swap
        tris[0].v0 = vtx(163, 161, 12'hf00, 32'h0004_0000);
        tris[0].v1 = vtx(357, 178, 12'h0f0, 32'h0010_0000);
        tris[0].v2 = vtx(198, 372, 12'h00f, 32'h0002_0000);
        tris[1].v0 = tris[0].v0;
        tris[1].v1 = tris[0].v2;
        tris[1].v2 = tris[0].v1;
        tris[2].v0 = vtx(480, 245, 12'h7c2, 32'h0003_8000);  // Flat
        tris[2].v1 = vtx(722, 320, 12'h7c2, 32'h0003_8000);
        tris[2].v2 = vtx(567, 499, 12'h7c2, 32'h0003_8000);
        // Past the right and bottom screen edges
        tris[3].v0 = vtx(2404, 1722, 12'h123, 32'h0000_8000);
        tris[3].v1 = vtx(2760, 1814, 12'h9af, 32'h0001_8000);
        tris[3].v2 = vtx(2465, 2045, 12'hf5e, 32'h0001_0000);
        tris[4].v0 = vtx(800, 800, 12'h0a5, 32'h0005_0000);
        tris[4].v1 = vtx(995, 832, 12'hf0f, 32'h0001_0000);
        tris[4].v2 = vtx(853, 1009, 12'h3c9, 32'h0003_0000);
        tris[5].v0 = vtx(1041, 1207, 12'h5f1, 32'hffff_0000);
        tris[5].v1 = vtx(1216, 1186, 12'hc3a, 32'h0002_0000);
        tris[5].v2 = vtx(1132, 1376, 12'h86d, 32'h0000_4000);
        foreach (tris[i]) begin
            cycle_limit += 19 + 2 * box_area(tris[i]);
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!out_valid && !busy && !tri_ready) else report_fail("not idle right after reset");
        @(negedge clk);
        assert (tri_ready) else report_fail("tri_ready low one cycle after reset");
        @(posedge clk);
        #1;

        saving = 1'b1;
        send_tri(tris[0]);
        wait_idle();
        saving   = 1'b0;
        matching = 1'b1;
        send_tri(tris[1]);
        wait_idle();
        matching = 1'b0;
        assert (saved_q.size() == 0) else report_fail("reverse winding lost pixels");
        send_tri(tris[2]);
        wait_idle();
        send_tri(tris[3]);
        wait_idle();

        // Second triangle goes in while the first is still walking
        random_ready = 1'b1;
        send_tri(tris[4]);
        send_tri(tris[5]);
        wait_idle();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: all.f
+incdir+testbench
src/raster_pkg.sv
src/recip_unit.sv
src/tri_setup.sv
src/bbox_walker.sv
src/pixel_eval.sv
src/raster_top.sv
testbench/raster_tb.sv
